// File: Makefile
VERILATOR ?= verilator
TOP       ?= bp_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	@./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "simulator exit status 0" $(LOG); then echo "Simulator aborted"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/bp_pkg.sv
package bp_pkg;

  localparam int N_ENTRIES = 8;
  localparam int ADDR_W    = 3;
  localparam int JSC_W     = 2;
  localparam int STAT_W    = 5;
  localparam int TREND_W   = 3;

  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [JSC_W-1:0]          jsc_t;  // MSB is the predicted direction.
  typedef logic [STAT_W-1:0]         stat_t;
  typedef logic signed [TREND_W-1:0] trend_t;

  typedef enum logic [1:0] {
    SRC_SP  = 2'd0,
    SRC_LHP = 2'd1,
    SRC_GHP = 2'd2
  } src_t;

  localparam stat_t  STAT_RESET = stat_t'(16);
  localparam trend_t TREND_MAX  = trend_t'(3);
  localparam trend_t TREND_MIN  = trend_t'(-3);

  typedef struct packed {
    logic   sp_bit;
    jsc_t   lhp_count;
    stat_t  sp_stat;
    stat_t  lhp_stat;
    stat_t  ghp_stat;
    trend_t sp_trend;
    trend_t lhp_trend;
    trend_t ghp_trend;
  } local_entry_t;

  typedef struct packed {
    jsc_t ghp_count;
  } global_entry_t;

  function automatic jsc_t jsc_next(jsc_t c, logic up);
    if (up)
      return (c == '1) ? c : c + 1'b1;
    return (c == '0) ? c : c - 1'b1;
  endfunction

  function automatic trend_t trend_next(trend_t t, logic correct);
    if (correct)
      return (t == TREND_MAX) ? t : t + trend_t'(1);
    return (t == TREND_MIN) ? t : t - trend_t'(1);
  endfunction

  // Saturates at zero; ovf flags an increment past the top.
  function automatic stat_t stat_next(stat_t s, logic correct, output logic ovf);
    ovf = correct && (s == '1);
    if (correct)
      return ovf ? s : s + 1'b1;
    return (s == '0) ? s : s - 1'b1;
  endfunction

endpackage

// File: hdl/bp_top.sv
`timescale 1ns/1ns

module bp_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          br_valid,
  input  bp_pkg::addr_t br_addr,
  input  logic          br_taken,
  input  logic          rollback,
  output logic          pred_valid,
  output logic          pred_taken,
  output bp_pkg::src_t  pred_src
);
  import bp_pkg::*;

  localparam local_entry_t LOCAL_RST = '{
    sp_bit:    1'b0,
    lhp_count: '0,
    sp_stat:   STAT_RESET,
    lhp_stat:  STAT_RESET,
    ghp_stat:  STAT_RESET,
    sp_trend:  '0,
    lhp_trend: '0,
    ghp_trend: '0
  };
  localparam global_entry_t GLOBAL_RST = '0;

  addr_t         ghr, global_idx;
  local_entry_t  local_rd, local_eff, snap_local;
  global_entry_t global_rd, global_eff, snap_global;
  logic          snap_hit_local, snap_hit_global;
  logic          sp_pred, lhp_pred, ghp_pred;
  logic          lk_taken;
  src_t          lk_src;

  logic          local_wr1_en, local_wr2_en;
  addr_t         local_wr1_addr, local_wr2_addr;
  local_entry_t  local_wr1_data, local_wr2_data;
  logic          global_wr1_en, global_wr2_en;
  addr_t         global_wr1_addr, global_wr2_addr;
  global_entry_t global_wr1_data, global_wr2_data;

  bp_entry_table #(.entry_t(local_entry_t)) local_tbl (
    .clk, .rst_n, .rd_addr(br_addr), .rd_data(local_rd),
    .wr1_en(local_wr1_en), .wr1_addr(local_wr1_addr), .wr1_data(local_wr1_data),
    .wr2_en(local_wr2_en), .wr2_addr(local_wr2_addr), .wr2_data(local_wr2_data),
    .rst_value(LOCAL_RST)
  );

  bp_entry_table #(.entry_t(global_entry_t)) global_tbl (
    .clk, .rst_n, .rd_addr(global_idx), .rd_data(global_rd),
    .wr1_en(global_wr1_en), .wr1_addr(global_wr1_addr), .wr1_data(global_wr1_data),
    .wr2_en(global_wr2_en), .wr2_addr(global_wr2_addr), .wr2_data(global_wr2_data),
    .rst_value(GLOBAL_RST)
  );

  bp_lookup u_lookup (
    .br_addr, .ghr, .snap_hit_local, .snap_hit_global, .snap_local, .snap_global,
    .local_rd, .global_rd, .global_idx, .local_eff, .global_eff,
    .sp_pred, .lhp_pred, .ghp_pred, .pred_taken(lk_taken), .pred_src(lk_src)
  );

  prediction_writer u_writer (
    .clk, .rst_n, .br_valid, .br_taken, .rollback, .br_addr, .global_idx,
    .local_eff, .global_eff, .sp_pred, .lhp_pred, .ghp_pred,
    .ghr, .snap_hit_local, .snap_hit_global, .snap_local, .snap_global,
    .local_wr1_en, .local_wr1_addr, .local_wr1_data,
    .local_wr2_en, .local_wr2_addr, .local_wr2_data,
    .global_wr1_en, .global_wr1_addr, .global_wr1_data,
    .global_wr2_en, .global_wr2_addr, .global_wr2_data
  );

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pred_valid <= 1'b0;
      pred_taken <= 1'b0;
      pred_src   <= SRC_LHP;
    end
    else
    begin
      pred_valid <= br_valid;
      if (br_valid)
      begin
        pred_taken <= lk_taken; // Pre-update view of the tables.
        pred_src   <= lk_src;
      end
    end
  end

endmodule

// File: hdl/prediction_writer.sv
`timescale 1ns/1ns

module prediction_writer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  br_valid,
  input  logic                  br_taken,
  input  logic                  rollback,
  input  bp_pkg::addr_t         br_addr,
  input  bp_pkg::addr_t         global_idx,
  input  bp_pkg::local_entry_t  local_eff,
  input  bp_pkg::global_entry_t global_eff,
  input  logic                  sp_pred,
  input  logic                  lhp_pred,
  input  logic                  ghp_pred,
  output bp_pkg::addr_t         ghr,
  output logic                  snap_hit_local,
  output logic                  snap_hit_global,
  output bp_pkg::local_entry_t  snap_local,
  output bp_pkg::global_entry_t snap_global,
  output logic                  local_wr1_en,
  output bp_pkg::addr_t         local_wr1_addr,
  output bp_pkg::local_entry_t  local_wr1_data,
  output logic                  local_wr2_en,
  output bp_pkg::addr_t         local_wr2_addr,
  output bp_pkg::local_entry_t  local_wr2_data,
  output logic                  global_wr1_en,
  output bp_pkg::addr_t         global_wr1_addr,
  output bp_pkg::global_entry_t global_wr1_data,
  output logic                  global_wr2_en,
  output bp_pkg::addr_t         global_wr2_addr,
  output bp_pkg::global_entry_t global_wr2_data
);
  import bp_pkg::*;

  addr_t         ghr_q;
  logic          snap_valid;
  addr_t         snap_laddr;
  addr_t         snap_gidx;
  addr_t         snap_ghr;
  logic          rb_ok;
  logic          sp_ok, lhp_ok, ghp_ok;
  logic          ovf_sp, ovf_lhp, ovf_ghp;
  local_entry_t  upd_local;
  global_entry_t upd_global;

  // Rollback only counts in the cycle right after a branch.
  assign rb_ok = rollback && snap_valid;

  // History the lookup sees, already rolled back.
  assign ghr = rb_ok ? snap_ghr : ghr_q;

  assign snap_hit_local  = rb_ok && br_valid && (snap_laddr == br_addr);
  assign snap_hit_global = rb_ok && br_valid && (snap_gidx == global_idx);

  assign sp_ok  = (sp_pred  == br_taken);
  assign lhp_ok = (lhp_pred == br_taken);
  assign ghp_ok = (ghp_pred == br_taken);

  always_comb
  begin
    upd_local           = local_eff;
    upd_local.sp_bit    = br_taken;
    upd_local.lhp_count = jsc_next(local_eff.lhp_count, br_taken);
    upd_local.sp_stat   = stat_next(local_eff.sp_stat, sp_ok, ovf_sp);
    upd_local.lhp_stat  = stat_next(local_eff.lhp_stat, lhp_ok, ovf_lhp);
    upd_local.ghp_stat  = stat_next(local_eff.ghp_stat, ghp_ok, ovf_ghp);
    upd_local.sp_trend  = trend_next(local_eff.sp_trend, sp_ok);
    upd_local.lhp_trend = trend_next(local_eff.lhp_trend, lhp_ok);
    upd_local.ghp_trend = trend_next(local_eff.ghp_trend, ghp_ok);
    if (ovf_sp || ovf_lhp || ovf_ghp)
    begin
      upd_local.sp_stat  = STAT_RESET; // Rescale the whole entry.
      upd_local.lhp_stat = STAT_RESET;
      upd_local.ghp_stat = STAT_RESET;
    end
    upd_global.ghp_count = jsc_next(global_eff.ghp_count, br_taken);
  end

  // Port 1 restores, unless port 2 already rewrites that index.
  assign local_wr1_en    = rb_ok && !snap_hit_local;
  assign local_wr1_addr  = snap_laddr;
  assign local_wr1_data  = snap_local;
  assign global_wr1_en   = rb_ok && !snap_hit_global;
  assign global_wr1_addr = snap_gidx;
  assign global_wr1_data = snap_global;

  assign local_wr2_en    = br_valid;
  assign local_wr2_addr  = br_addr;
  assign local_wr2_data  = upd_local;
  assign global_wr2_en   = br_valid;
  assign global_wr2_addr = global_idx;
  assign global_wr2_data = upd_global;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ghr_q      <= '0;
      snap_valid <= 1'b0;
    end
    else
    begin
      snap_valid <= br_valid; // One cycle only.
      if (br_valid)
      begin
        ghr_q <= {ghr[ADDR_W-2:0], br_taken};
      end
      else if (rb_ok)
      begin
        ghr_q <= snap_ghr;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (br_valid)
    begin
      snap_local  <= local_eff;
      snap_global <= global_eff;
      snap_laddr  <= br_addr;
      snap_gidx   <= global_idx;
      snap_ghr    <= ghr;
    end
  end

endmodule

// File: predictor_table/bp_entry_table.sv
`timescale 1ns/1ns

module bp_entry_table #(
  parameter type entry_t = logic
) (
  input  logic           clk,
  input  logic           rst_n,
  input  bp_pkg::addr_t  rd_addr,
  input  logic           wr1_en,
  input  bp_pkg::addr_t  wr1_addr,
  input  entry_t         wr1_data,
  input  logic           wr2_en,
  input  bp_pkg::addr_t  wr2_addr,
  input  entry_t         wr2_data,
  input  entry_t         rst_value,
  output entry_t         rd_data
);
  import bp_pkg::*;

  entry_t mem [N_ENTRIES];

  // Combinational read.
  assign rd_data = mem[rd_addr];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < N_ENTRIES; i++)
      begin
        mem[i] <= rst_value;
      end
    end
    else
    begin
      if (wr1_en)
      begin
        mem[wr1_addr] <= wr1_data;
      end
      // Port 2 last, so it wins on a shared index.
      if (wr2_en)
      begin
        mem[wr2_addr] <= wr2_data;
      end
    end
  end

endmodule

// File: predictor_table/bp_lookup.sv
`timescale 1ns/1ns

module bp_lookup (
  input  bp_pkg::addr_t         br_addr,
  input  bp_pkg::addr_t         ghr,
  input  logic                  snap_hit_local,
  input  logic                  snap_hit_global,
  input  bp_pkg::local_entry_t  snap_local,
  input  bp_pkg::global_entry_t snap_global,
  input  bp_pkg::local_entry_t  local_rd,
  input  bp_pkg::global_entry_t global_rd,
  output bp_pkg::addr_t         global_idx,
  output bp_pkg::local_entry_t  local_eff,
  output bp_pkg::global_entry_t global_eff,
  output logic                  sp_pred,
  output logic                  lhp_pred,
  output logic                  ghp_pred,
  output logic                  pred_taken,
  output bp_pkg::src_t          pred_src
);
  import bp_pkg::*;

  // Strictly better on stat, then on trend.
  function automatic logic beats(stat_t sa, trend_t ta, stat_t sb, trend_t tb);
    return (sa > sb) || ((sa == sb) && (ta > tb));
  endfunction

  assign global_idx = br_addr ^ ghr;

  // Same-cycle rollback replaces the table contents.
  assign local_eff  = snap_hit_local  ? snap_local  : local_rd;
  assign global_eff = snap_hit_global ? snap_global : global_rd;

  assign sp_pred  = local_eff.sp_bit;
  assign lhp_pred = local_eff.lhp_count[JSC_W-1];
  assign ghp_pred = global_eff.ghp_count[JSC_W-1];

  always_comb
  begin
    stat_t  best_stat;
    trend_t best_trend;
    // LHP holds ties, then GHP, then SP.
    pred_src   = SRC_LHP;
    best_stat  = local_eff.lhp_stat;
    best_trend = local_eff.lhp_trend;
    if (beats(local_eff.ghp_stat, local_eff.ghp_trend, best_stat, best_trend))
    begin
      pred_src   = SRC_GHP;
      best_stat  = local_eff.ghp_stat;
      best_trend = local_eff.ghp_trend;
    end
    if (beats(local_eff.sp_stat, local_eff.sp_trend, best_stat, best_trend))
    begin
      pred_src = SRC_SP;
    end
  end

  always_comb
  begin
    case (pred_src)
      SRC_SP:  pred_taken = sp_pred;
      SRC_GHP: pred_taken = ghp_pred;
      default: pred_taken = lhp_pred;
    endcase
  end

endmodule

// File: verif/bp_checker.sv
`timescale 1ns/1ns

module bp_checker (
  input logic         clk,
  input logic         rst_n,
  input logic         br_valid,
  input logic         pred_valid,
  input bp_pkg::src_t pred_src
);
  import bp_pkg::*;

  int unsigned fails = 0;

  // One cycle from branch strobe to prediction strobe.
  a_pred_follows: assert property (@(posedge clk) disable iff (!rst_n)
    br_valid |=> pred_valid)
  else
  begin
    fails++;
    $error("pred_valid missing one cycle after br_valid");
  end

  a_pred_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !br_valid |=> !pred_valid)
  else
  begin
    fails++;
    $error("pred_valid high without a branch in the cycle before");
  end

  a_reset_low: assert property (@(posedge clk) !rst_n |=> !pred_valid)
  else
  begin
    fails++;
    $error("pred_valid high during reset");
  end

  a_src_legal: assert property (@(posedge clk) disable iff (!rst_n)
    pred_src inside {SRC_SP, SRC_LHP, SRC_GHP})
  else
  begin
    fails++;
    $error("pred_src holds an illegal value");
  end

endmodule

// File: verif/bp_tb.sv
`timescale 1ns/1ns

module bp_tb;
  import bp_pkg::*;

  localparam int RAND_CYCLES = 3000;
  localparam int RST_TIMEOUT = 50;

  logic  clk;
  logic  rst_n;
  logic  br_valid;
  addr_t br_addr;
  logic  br_taken;
  logic  rollback;
  logic  pred_valid;
  logic  pred_taken;
  src_t  pred_src;

  // Reference model state.
  local_entry_t  m_local [N_ENTRIES];
  global_entry_t m_global [N_ENTRIES];
  addr_t         m_ghr;
  logic          m_snap_valid;
  local_entry_t  m_snap_local;
  global_entry_t m_snap_global;
  addr_t         m_snap_laddr;
  addr_t         m_snap_gidx;
  addr_t         m_snap_ghr;
  logic          exp_valid;
  logic          exp_taken;
  src_t          exp_src;

  int            errors;
  int            checks;
  logic          timed_out;
  int unsigned   bias [N_ENTRIES]; // Percent taken per address.

  bp_top DUT (
    .clk, .rst_n, .br_valid, .br_addr, .br_taken, .rollback,
    .pred_valid, .pred_taken, .pred_src
  );

  bind bp_top bp_checker u_checker (.clk, .rst_n, .br_valid, .pred_valid, .pred_src);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  function automatic int sat_step(int v, logic up, int lo, int hi);
    int n;
    n = up ? v + 1 : v - 1;
    if (n > hi)
      n = hi;
    if (n < lo)
      n = lo;
    return n;
  endfunction

  // Stat dominates, trend only breaks ties.
  function automatic int chooser_score(stat_t s, trend_t t);
    return int'(s) * 8 + int'(t) + 3;
  endfunction

  function automatic logic draw_outcome(addr_t a);
    return ($urandom % 100) < bias[a];
  endfunction

  task automatic model_reset();
    for (int i = 0; i < N_ENTRIES; i++)
    begin
      m_local[i]          = '0;
      m_local[i].sp_stat  = STAT_RESET;
      m_local[i].lhp_stat = STAT_RESET;
      m_local[i].ghp_stat = STAT_RESET;
      m_global[i]         = '0;
    end
    m_ghr        = '0;
    m_snap_valid = 1'b0;
    exp_valid    = 1'b0;
    exp_taken    = 1'b0;
    exp_src      = SRC_LHP;
  endtask

  task automatic model_step(input logic v, input addr_t a, input logic t, input logic rb);
    local_entry_t  le;
    local_entry_t  nl;
    global_entry_t ge;
    addr_t         g;
    addr_t         gi;
    logic          rb_ok;
    logic          hit_l;
    logic          hit_g;
    logic          sp_ok;
    logic          lhp_ok;
    logic          ghp_ok;
    int            s_sp;
    int            s_lhp;
    int            s_ghp;
    rb_ok = rb && m_snap_valid;
    g     = rb_ok ? m_snap_ghr : m_ghr;
    gi    = a ^ g;
    hit_l = rb_ok && v && (a == m_snap_laddr);
    hit_g = rb_ok && v && (gi == m_snap_gidx);
    le    = hit_l ? m_snap_local : m_local[a];
    ge    = hit_g ? m_snap_global : m_global[gi];
    nl    = le;
    exp_valid = v;
    if (v)
    begin
      s_sp  = chooser_score(le.sp_stat, le.sp_trend);
      s_lhp = chooser_score(le.lhp_stat, le.lhp_trend);
      s_ghp = chooser_score(le.ghp_stat, le.ghp_trend);
      if (s_lhp >= s_ghp && s_lhp >= s_sp)
        exp_src = SRC_LHP;
      else if (s_ghp >= s_sp)
        exp_src = SRC_GHP;
      else
        exp_src = SRC_SP;
      sp_ok  = (le.sp_bit == t);
      lhp_ok = (le.lhp_count[JSC_W-1] == t);
      ghp_ok = (ge.ghp_count[JSC_W-1] == t);
      case (exp_src)
        SRC_SP:  exp_taken = le.sp_bit;
        SRC_GHP: exp_taken = ge.ghp_count[JSC_W-1];
        default: exp_taken = le.lhp_count[JSC_W-1];
      endcase
      nl.sp_bit    = t;
      nl.lhp_count = jsc_t'(sat_step(int'(le.lhp_count), t, 0, 3));
      nl.sp_stat   = stat_t'(sat_step(int'(le.sp_stat), sp_ok, 0, 31));
      nl.lhp_stat  = stat_t'(sat_step(int'(le.lhp_stat), lhp_ok, 0, 31));
      nl.ghp_stat  = stat_t'(sat_step(int'(le.ghp_stat), ghp_ok, 0, 31));
      nl.sp_trend  = trend_t'(sat_step(int'(le.sp_trend), sp_ok, -3, 3));
      nl.lhp_trend = trend_t'(sat_step(int'(le.lhp_trend), lhp_ok, -3, 3));
      nl.ghp_trend = trend_t'(sat_step(int'(le.ghp_trend), ghp_ok, -3, 3));
      if ((sp_ok && le.sp_stat == 5'd31) || (lhp_ok && le.lhp_stat == 5'd31) ||
          (ghp_ok && le.ghp_stat == 5'd31))
      begin
        nl.sp_stat  = STAT_RESET;
        nl.lhp_stat = STAT_RESET;
        nl.ghp_stat = STAT_RESET;
      end
    end
    if (rb_ok && !hit_l)
      m_local[m_snap_laddr] = m_snap_local;
    if (rb_ok && !hit_g)
      m_global[m_snap_gidx] = m_snap_global;
    if (v)
    begin
      m_local[a]             = nl;
      m_global[gi].ghp_count = jsc_t'(sat_step(int'(ge.ghp_count), t, 0, 3));
      m_snap_local           = le;
      m_snap_global          = ge;
      m_snap_laddr           = a;
      m_snap_gidx            = gi;
      m_snap_ghr             = g;
      m_ghr                  = {g[ADDR_W-2:0], t};
    end
    else if (rb_ok)
      m_ghr = m_snap_ghr;
    m_snap_valid = v;
  endtask

  // Checks last cycle's prediction, then applies the next stimulus.
  task automatic drive_cycle(input logic v, input addr_t a, input logic t, input logic rb);
    @(negedge clk);
    checks++;
    if (pred_valid !== exp_valid)
    begin
      errors++;
      $display("Error at %0t: pred_valid %b, expected %b", $time, pred_valid, exp_valid);
    end
    if (exp_valid && (pred_taken !== exp_taken || pred_src !== exp_src))
    begin
      errors++;
      $display("Error at %0t: prediction %b from %s, expected %b from %s", $time,
               pred_taken, pred_src.name(), exp_taken, exp_src.name());
    end
    br_valid = v;
    br_addr  = a;
    br_taken = t;
    rollback = rb;
    model_step(v, a, t, rb);
  endtask

  initial
  begin
    int          waited;
    addr_t       a;
    logic        v;
    logic        rb;
    br_valid  = 1'b0;
    br_addr   = '0;
    br_taken  = 1'b0;
    rollback  = 1'b0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    void'($urandom(32'ha2ea_6de2));
    for (int i = 0; i < N_ENTRIES; i++)
      bias[i] = $urandom % 100;
    model_reset();
    waited = 0;
    while (rst_n !== 1'b1 && waited < RST_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1)
    begin
      timed_out = 1'b1;
      $display("Reset was never released within %0d cycles.", RST_TIMEOUT);
    end
    else
    begin
      for (int i = 0; i < N_ENTRIES; i++)
        drive_cycle(1'b1, addr_t'(i), 1'b1, 1'b0); // Cold entries.
      repeat (40) drive_cycle(1'b1, addr_t'(3), 1'b1, 1'b0);
      repeat (40) drive_cycle(1'b1, addr_t'(3), 1'b0, 1'b0);
      drive_cycle(1'b1, addr_t'(5), 1'b1, 1'b0);
      drive_cycle(1'b0, addr_t'(0), 1'b0, 1'b1); // Restore.
      drive_cycle(1'b1, addr_t'(5), 1'b1, 1'b0);
      drive_cycle(1'b0, addr_t'(0), 1'b0, 1'b0);
      drive_cycle(1'b0, addr_t'(0), 1'b0, 1'b1); // Stale, no effect.
      drive_cycle(1'b1, addr_t'(2), 1'b0, 1'b0);
      drive_cycle(1'b1, addr_t'(2), 1'b1, 1'b1); // Collision on the same index.
      drive_cycle(1'b1, addr_t'(6), 1'b1, 1'b0);
      drive_cycle(1'b1, addr_t'(1), 1'b0, 1'b1);
      drive_cycle(1'b1, addr_t'(1), 1'b1, 1'b0);
      for (int n = 0; n < RAND_CYCLES; n++)
      begin
        a  = addr_t'($urandom % N_ENTRIES);
        v  = ($urandom % 100) < 70;
        rb = ($urandom % 100) < 15;
        drive_cycle(v, a, draw_outcome(a), rb);
      end
      drive_cycle(1'b0, addr_t'(0), 1'b0, 1'b0);
    end
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             checks, errors, DUT.u_checker.fails);
    if (errors == 0 && DUT.u_checker.fails == 0 && !timed_out)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verilog.f
common/bp_pkg.sv
predictor_table/bp_entry_table.sv
predictor_table/bp_lookup.sv
hdl/prediction_writer.sv
hdl/bp_top.sv
verif/bp_checker.sv
verif/bp_tb.sv
